/* flist.f */
common/rx_cfg_pkg.sv
common/rx_types_pkg.sv
source/iq_scaler.sv
preamble_detect/preamble_detect.sv
tag_rx/tag_rx.sv
source/tag_rx_ctrl.sv
sim/tag_rx_ctrl_checker.sv
sim/tag_rx_ctrl_tb.sv

/* Bender.yml */
package:
  name: tag_rx_ctrl

sources:
  - files:
      - common/rx_cfg_pkg.sv
      - common/rx_types_pkg.sv
      - source/iq_scaler.sv
      - preamble_detect/preamble_detect.sv
      - tag_rx/tag_rx.sv
      - source/tag_rx_ctrl.sv
  - target: simulation
    files:
      - sim/tag_rx_ctrl_checker.sv
      - sim/tag_rx_ctrl_tb.sv

/* sim/tag_rx_ctrl_tb.sv */
module tag_rx_ctrl_tb;

  localparam int DEC_RATE      = 8;
  localparam int NRX_TRIG      = 4;
  localparam int NSYNCP        = 32;
  localparam int NSYNCN        = 32;
  localparam int NSYMB         = 16;
  localparam int NLOC_PER_SYNC = 3;
  localparam int SYNC_LEN      = NSYNCP + NSYNCN - (NRX_TRIG - 1) * DEC_RATE;
  localparam int RX_LEN        = NLOC_PER_SYNC * NSYMB;
  localparam int RESET_CYCLES  = 16;

  typedef struct {
    string       name;
    logic [15:0] scale;
    logic [31:0] thres;
    int          burst_i;
    int          burst_q;
    int          blocks;    // Burst length in energy blocks.
    int          exp_trig;  // Expected number of detect strobes.
    int          run_len;   // Cycles with run_rx high.
  } row_t;

  logic                    clk;
  logic                    i_reset;
  logic                    i_run_rx;
  rx_types_pkg::iq_t       i_rx;
  logic [15:0]             i_scale_val;
  logic [31:0]             i_noise_thres;
  logic                    o_rx_valid;
  rx_types_pkg::iq_t       o_rx_bb;
  logic                    o_rx_trig;
  rx_types_pkg::rx_state_t o_rx_state;
  logic                    o_peak_detect_stb;
  rx_types_pkg::rx_debug_t o_debug;
  rx_types_pkg::gpio_t     o_fp_gpio;

  row_t rows[$];
  int   seed = 32'hd5b9;
  int   errors = 0;
  int   cycle_count = 0;
  int   cycle_limit = 0;

  // Reference model, values valid in the current cycle.
  rx_types_pkg::iq_t       m_scaled;
  rx_types_pkg::iq_t       m_scaled_prev;
  rx_types_pkg::iq_t       m_out;
  rx_types_pkg::iq_t       prev_drive;
  rx_types_pkg::rx_state_t m_state;
  rx_types_pkg::gpio_t     m_gpio;
  rx_types_pkg::rx_debug_t m_debug;
  logic                    m_chk;
  logic                    m_pvalid;
  logic                    m_stb;
  logic                    m_thres;
  logic                    m_valid;
  logic                    m_trig;
  longint                  m_acc;
  int                      m_run;
  int                      m_cnt;
  int                      m_rxk;
  int                      m_tcnt;  // Downconverter sample count, -1 while unknown.
  logic [15:0]             eff_scale;
  logic [31:0]             cur_thres;

  tag_rx_ctrl #(
    .DEC_RATE      (DEC_RATE),
    .NRX_TRIG      (NRX_TRIG),
    .NSYNCP        (NSYNCP),
    .NSYNCN        (NSYNCN),
    .NSYMB         (NSYMB),
    .NLOC_PER_SYNC (NLOC_PER_SYNC)
  ) UUT (
    .clk               (clk),
    .i_reset           (i_reset),
    .i_run_rx          (i_run_rx),
    .i_rx              (i_rx),
    .i_scale_val       (i_scale_val),
    .i_noise_thres     (i_noise_thres),
    .o_rx_valid        (o_rx_valid),
    .o_rx_bb           (o_rx_bb),
    .o_rx_trig         (o_rx_trig),
    .o_rx_state        (o_rx_state),
    .o_peak_detect_stb (o_peak_detect_stb),
    .o_debug           (o_debug),
    .o_fp_gpio         (o_fp_gpio)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Reference functions
  //////////////////////////////

  function automatic logic signed [15:0] scale_comp(input int x, input int s);
    longint p;
    p = longint'(x) * longint'(s);
    p = p >>> rx_cfg_pkg::SCALE_SHIFT;  // Floor.
    if (p > 32767) begin
      p = 32767;
    end else if (p < -32768) begin
      p = -32768;
    end
    scale_comp = p[15:0];
  endfunction

  function automatic int magnitude(input logic signed [15:0] x);
    magnitude = (x < 0) ? -int'(x) : int'(x);
  endfunction

  function automatic rx_types_pkg::iq_t rotate_ref(input rx_types_pkg::iq_t s, input int k);
    rx_types_pkg::iq_t r;
    case (k % 4)
      0: r = s;
      1: begin
        r.i = s.q;
        r.q = -s.i;
      end
      2: begin
        r.i = -s.i;
        r.q = -s.q;
      end
      default: begin
        r.i = -s.q;
        r.q = s.i;
      end
    endcase
    rotate_ref = r;
  endfunction

  task automatic add_row(input string name, input logic [15:0] scale, input logic [31:0] thres,
                         input int bi, input int bq, input int blocks, input int exp_trig,
                         input int run_len);
    row_t r;
    r.name     = name;
    r.scale    = scale;
    r.thres    = thres;
    r.burst_i  = bi;
    r.burst_q  = bq;
    r.blocks   = blocks;
    r.exp_trig = exp_trig;
    r.run_len  = run_len;
    rows.push_back(r);
  endtask

  task automatic model_clear();
    m_scaled      = '0;
    m_scaled_prev = '0;
    m_out         = '0;
    m_state       = rx_types_pkg::S_INIT;
    m_gpio        = '0;
    m_debug       = '0;
    m_chk         = 1'b0;
    m_pvalid      = 1'b0;
    m_stb         = 1'b0;
    m_thres       = 1'b0;
    m_valid       = 1'b0;
    m_trig        = 1'b0;
    m_acc         = 0;
    m_run         = 0;
    m_cnt         = 0;
    m_rxk         = 0;
    m_tcnt        = -1;
  endtask

  // Step from cycle n-1 to cycle n.
  task automatic model_advance(input int n);
    longint sum;
    logic   blk_end;
    logic   above;
    m_gpio            = '0;
    m_gpio.sync_out   = (m_state == rx_types_pkg::S_LOC_SYNC);
    m_gpio.thres_trig = m_thres;
    m_chk             = 1'b1;
    if (m_state == rx_types_pkg::S_LOC_SYNC) begin
      m_out.i = (m_cnt < NSYNCP) ? rx_cfg_pkg::SYNC_AMP : -rx_cfg_pkg::SYNC_AMP;
      m_out.q = '0;
    end else if (m_state == rx_types_pkg::S_LOC_RX) begin
      m_out = rotate_ref(m_scaled_prev, m_rxk - 1);  // Rotation starts at 0.
    end else begin
      m_chk = 1'b0;
    end
    if (m_trig) begin
      m_tcnt = 0;  // Downconverter held by the trigger.
    end else if (m_tcnt >= 0) begin
      m_tcnt = (m_tcnt + 1) % RX_LEN;
    end
    case (m_state)
      rx_types_pkg::S_INIT: begin
        if (m_pvalid && m_stb) begin
          m_state = rx_types_pkg::S_LOC_SYNC;
          m_cnt   = 0;
          m_valid = 1'b1;
          m_trig  = 1'b1;
        end else if (m_pvalid) begin
          m_valid = 1'b0;
        end
      end
      rx_types_pkg::S_LOC_SYNC: begin
        if (m_cnt == SYNC_LEN - 1) begin
          m_state = rx_types_pkg::S_LOC_RX;
          m_rxk   = 1;
        end else begin
          m_cnt  = m_cnt + 1;
          m_trig = (m_cnt < SYNC_LEN - 1);
        end
      end
      default: begin
        if (m_rxk == RX_LEN) begin
          m_state = rx_types_pkg::S_INIT;
        end else begin
          m_rxk = m_rxk + 1;
        end
      end
    endcase
    m_debug.phase      = 2'(m_tcnt % 4);
    m_debug.symb_n     = 16'(m_tcnt % NSYMB);
    m_debug.sync_count = 16'(m_cnt);
    sum      = m_acc + magnitude(m_scaled.i) + magnitude(m_scaled.q);
    blk_end  = (((n - 1) % DEC_RATE) == DEC_RATE - 1);
    m_pvalid = blk_end;
    m_stb    = 1'b0;
    if (blk_end) begin
      above   = (sum > longint'(cur_thres));
      m_thres = above;
      m_acc   = 0;
      if (above) begin
        m_stb = (m_run == NRX_TRIG - 1);
        if (m_run < NRX_TRIG) begin
          m_run = m_run + 1;
        end
      end else begin
        m_run = 0;
      end
    end else begin
      m_acc = sum;
    end
    m_scaled_prev = m_scaled;
    m_scaled.i    = scale_comp(int'(prev_drive.i), int'(eff_scale));
    m_scaled.q    = scale_comp(int'(prev_drive.q), int'(eff_scale));
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_iq(input string name, input rx_types_pkg::iq_t exp,
                          input rx_types_pkg::iq_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected (%0d, %0d) actual (%0d, %0d)",
               name, exp.i, exp.q, act.i, act.q);
    end
  endtask

  task automatic check_state(input string name, input rx_types_pkg::rx_state_t exp,
                             input rx_types_pkg::rx_state_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_gpio(input string name, input rx_types_pkg::gpio_t exp,
                            input rx_types_pkg::gpio_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %03h actual %03h", name, exp, act);
    end
  endtask

  task automatic check_debug(input string name, input rx_types_pkg::rx_debug_t exp,
                             input rx_types_pkg::rx_debug_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %0d/%0d/%0d actual %0d/%0d/%0d", name,
               exp.phase, exp.symb_n, exp.sync_count, act.phase, act.symb_n, act.sync_count);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_idle(input string name, input logic with_gpio);
    check_state({name, " state"}, rx_types_pkg::S_INIT, o_rx_state);
    check_bit({name, " rx_valid"}, 1'b0, o_rx_valid);
    check_bit({name, " rx_trig"}, 1'b0, o_rx_trig);
    check_bit({name, " peak_stb"}, 1'b0, o_peak_detect_stb);
    if (with_gpio) begin
      check_gpio({name, " gpio"}, '0, o_fp_gpio);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rx_types_pkg::iq_t drv;
    int                noise_i;
    int                noise_q;
    int                stb_seen;
    int                b_lo;
    int                b_hi;
    row_t              r;
    add_row("noise_only", 16'd256, 32'd2000, 0, 0, 0, 0, 120);
    add_row("burst_basic", 16'd256, 32'd2000, 1000, -600, 6, 1, 176);
    add_row("scale_one", 16'd1, 32'd200, 20000, 12000, 6, 1, 176);
    add_row("scale_zero", 16'd0, 32'd200, 20000, 12000, 6, 1, 176);
    add_row("saturate", 16'd1000, 32'd3000, 16000, 9000, 6, 1, 176);
    add_row("short_burst", 16'd256, 32'd2000, 1000, 1000, 2, 0, 120);
    add_row("abort_in_rx", 16'd256, 32'd2000, 1000, -600, 6, 1, 110);  // Drops run_rx in LOC_RX.
    cycle_limit = RESET_CYCLES + 50;
    foreach (rows[k]) begin
      cycle_limit += rows[k].run_len + 2;
    end

    clk           = 1'b0;
    i_reset       = 1'b1;
    i_run_rx      = 1'b0;
    i_rx          = '0;
    i_scale_val   = 16'd1;
    i_noise_thres = '0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      @(negedge clk);
      check_idle("reset", 1'b1);
    end
    @(posedge clk);
    i_reset <= 1'b0;

    foreach (rows[k]) begin
      r = rows[k];
      @(posedge clk);
      i_run_rx      <= 1'b0;
      i_rx          <= '0;
      i_scale_val   <= r.scale;
      i_noise_thres <= r.thres;
      @(posedge clk);
      @(negedge clk);
      check_idle({r.name, " clear"}, 1'b0);

      eff_scale = (r.scale == 16'd0) ? 16'd1 : r.scale;
      cur_thres = r.thres;
      b_lo      = 1 + 2 * DEC_RATE;
      b_hi      = 1 + (2 + r.blocks) * DEC_RATE;
      stb_seen  = 0;
      for (int n = 0; n < r.run_len; n++) begin
        if (n == 0) begin
          drv = '0;
        end else begin
          noise_i = $random(seed) % 4;
          noise_q = $random(seed) % 4;
          if (n >= b_lo && n < b_hi) begin
            noise_i += r.burst_i;
            noise_q += r.burst_q;
          end
          drv.i = noise_i[15:0];
          drv.q = noise_q[15:0];
        end
        @(posedge clk);
        i_run_rx <= 1'b1;
        i_rx     <= drv;
        @(negedge clk);
        if (n == 0) begin
          model_clear();
        end else begin
          model_advance(n);
        end
        prev_drive = drv;
        check_state({r.name, " state"}, m_state, o_rx_state);
        check_bit({r.name, " rx_valid"}, m_valid, o_rx_valid);
        check_bit({r.name, " rx_trig"}, m_trig, o_rx_trig);
        check_bit({r.name, " peak_stb"}, m_stb, o_peak_detect_stb);
        check_gpio({r.name, " gpio"}, m_gpio, o_fp_gpio);
        if (m_chk) begin
          check_iq({r.name, " rx_bb"}, m_out, o_rx_bb);
        end
        if (m_tcnt >= 0) begin
          check_debug({r.name, " debug"}, m_debug, o_debug);
        end
        if (o_peak_detect_stb === 1'b1) begin
          stb_seen++;
        end
      end
      check_count({r.name, " strobe count"}, r.exp_trig, stb_seen);
    end

    @(posedge clk);
    i_run_rx <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_idle("final clear", 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_idle("final idle", 1'b1);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/tag_rx_ctrl_checker.sv */
module tag_rx_ctrl_checker (
  input logic                    clk,
  input logic                    i_reset,
  input logic                    i_run_rx,
  input logic                    o_rx_trig,
  input rx_types_pkg::rx_state_t o_rx_state,
  input logic                    o_peak_detect_stb,
  input rx_types_pkg::gpio_t     o_fp_gpio
);

  logic clear;

  assign clear = i_reset | ~i_run_rx;

  // Trigger low inside the sync state only in its last cycle.
  trig_fall_last: assert property (@(posedge clk) disable iff (clear)
    (o_rx_state == rx_types_pkg::S_LOC_SYNC && !o_rx_trig)
      |=> (o_rx_state == rx_types_pkg::S_LOC_RX))
    else $error("rx_trig low in sync state before its last cycle");

  stb_single: assert property (@(posedge clk) disable iff (clear)
    o_peak_detect_stb |=> !o_peak_detect_stb)
    else $error("peak detect strobe longer than one cycle");

  gpio_sync_bit: assert property (@(posedge clk) disable iff (i_reset)
    o_fp_gpio.sync_out == ($past(o_rx_state) == rx_types_pkg::S_LOC_SYNC))
    else $error("gpio sync bit does not follow the sync state");

endmodule

bind tag_rx_ctrl tag_rx_ctrl_checker checker_inst (
  .clk               (clk),
  .i_reset           (i_reset),
  .i_run_rx          (i_run_rx),
  .o_rx_trig         (o_rx_trig),
  .o_rx_state        (o_rx_state),
  .o_peak_detect_stb (o_peak_detect_stb),
  .o_fp_gpio         (o_fp_gpio)
);

/* source/tag_rx_ctrl.sv */
module tag_rx_ctrl #(
  parameter int DEC_RATE      = 64,
  parameter int NRX_TRIG      = 16,
  parameter int NSYNCP        = 16384,  // Cycles of positive sync level.
  parameter int NSYNCN        = 16384,
  parameter int NSYMB         = 512,
  parameter int NLOC_PER_SYNC = 7
)(
  input  logic                                clk,
  input  logic                                i_reset,
  input  logic                                i_run_rx,
  input  rx_types_pkg::iq_t                   i_rx,
  input  logic [rx_cfg_pkg::DATA_WIDTH-1:0]   i_scale_val,
  input  logic [2*rx_cfg_pkg::DATA_WIDTH-1:0] i_noise_thres,
  output logic                                o_rx_valid,
  output rx_types_pkg::iq_t                   o_rx_bb,
  output logic                                o_rx_trig,
  output rx_types_pkg::rx_state_t             o_rx_state,
  output logic                                o_peak_detect_stb,
  output rx_types_pkg::rx_debug_t             o_debug,
  output rx_types_pkg::gpio_t                 o_fp_gpio
);

  localparam int W              = rx_cfg_pkg::DATA_WIDTH;
  localparam int NRX_TRIG_DELAY = (NRX_TRIG - 1) * DEC_RATE;
  localparam int SYNC_LEN       = NSYNCP + NSYNCN - NRX_TRIG_DELAY;  // Cut by detect delay.

  logic                    clear;
  logic [W-1:0]            scale_reg;
  logic [15:0]             sync_count;
  rx_types_pkg::rx_state_t state;
  rx_types_pkg::iq_t       scaled;
  rx_types_pkg::iq_t       bb;
  rx_types_pkg::iq_t       sync_sample;
  rx_types_pkg::iq_t       out_sample;
  rx_types_pkg::rx_debug_t tag_debug;
  rx_types_pkg::gpio_t     gpio_next;
  logic                    sync_ready;
  logic                    peak_valid;
  logic                    peak_stb;
  logic                    peak_thres;

  assign clear = i_reset | ~i_run_rx;

  //////////////////////////////
  // Scaling and detection
  //////////////////////////////

  iq_scaler scaler (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_clear  (clear),
    .i_scale  (scale_reg),
    .i_sample (i_rx),
    .o_sample (scaled)
  );

  preamble_detect #(
    .DEC_RATE (DEC_RATE),
    .NRX_TRIG (NRX_TRIG)
  ) prmb (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_clear       (clear),
    .i_sample      (scaled),
    .i_noise_thres (i_noise_thres),
    .o_peak_valid  (peak_valid),
    .o_peak_stb    (peak_stb),
    .o_peak_thres  (peak_thres)
  );

  tag_rx #(
    .NSYMB         (NSYMB),
    .NLOC_PER_SYNC (NLOC_PER_SYNC)
  ) rxb (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_srst       (o_rx_trig),  // Counters held until the sync ends.
    .i_sample     (scaled),
    .o_bb         (bb),
    .o_sync_ready (sync_ready),
    .o_debug      (tag_debug)
  );

  //////////////////////////////
  // Receive state machine
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (clear) begin
      o_rx_valid <= 1'b0;
      o_rx_trig  <= 1'b0;
      state      <= rx_types_pkg::S_INIT;
      sync_count <= '0;
      scale_reg  <= W'(1);
    end else begin
      case (state)
        rx_types_pkg::S_INIT: begin
          scale_reg <= (i_scale_val == '0) ? W'(1) : i_scale_val;
          if (peak_valid) begin
            if (peak_stb) begin
              state      <= rx_types_pkg::S_LOC_SYNC;
              o_rx_valid <= 1'b1;
              o_rx_trig  <= 1'b1;
              sync_count <= '0;
            end else begin
              o_rx_valid <= 1'b0;
            end
          end
        end
        rx_types_pkg::S_LOC_SYNC: begin
          if (sync_count == 16'(SYNC_LEN - 1)) begin
            state <= rx_types_pkg::S_LOC_RX;
          end else begin
            sync_count <= sync_count + 1'b1;
            o_rx_trig  <= (sync_count < 16'(SYNC_LEN - 2));  // Low in the last cycle.
          end
        end
        rx_types_pkg::S_LOC_RX: begin
          if (sync_ready) begin
            state <= rx_types_pkg::S_INIT;
          end
        end
        default: state <= rx_types_pkg::S_INIT;
      endcase
    end
  end

  //////////////////////////////
  // Output select
  //////////////////////////////

  always_comb begin
    sync_sample.i = (sync_count < NSYNCP) ? rx_cfg_pkg::SYNC_AMP : -rx_cfg_pkg::SYNC_AMP;
    sync_sample.q = '0;
    out_sample = (state == rx_types_pkg::S_LOC_SYNC) ? sync_sample : bb;
  end

  always_ff @(posedge clk) begin
    if (clear) begin
      o_rx_bb <= '0;
    end else begin
      o_rx_bb <= out_sample;
    end
  end

  // Front panel bits.
  always_comb begin
    gpio_next            = '0;
    gpio_next.sync_out   = (state == rx_types_pkg::S_LOC_SYNC);
    gpio_next.thres_trig = peak_thres;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_fp_gpio <= '0;
    end else begin
      o_fp_gpio <= gpio_next;
    end
  end

  assign o_rx_state        = state;
  assign o_peak_detect_stb = peak_stb;
  assign o_debug = '{phase: tag_debug.phase, symb_n: tag_debug.symb_n, sync_count: sync_count};

endmodule

/* tag_rx/tag_rx.sv */
module tag_rx #(
  parameter int NSYMB         = 512,  // Symbols per local interval.
  parameter int NLOC_PER_SYNC = 7     // Local intervals per sync.
)(
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_srst,
  input  rx_types_pkg::iq_t       i_sample,
  output rx_types_pkg::iq_t       o_bb,
  output logic                    o_sync_ready,
  output rx_types_pkg::rx_debug_t o_debug
);

  localparam int PW    = rx_cfg_pkg::PHASE_WIDTH;
  localparam int SW    = rx_cfg_pkg::NSYMB_WIDTH;
  localparam int LOC_W = (NLOC_PER_SYNC > 1) ? $clog2(NLOC_PER_SYNC) : 1;

  logic [PW-1:0]    phase;
  logic [SW-1:0]    symb_n;
  logic [LOC_W-1:0] loc_n;
  logic             symb_last;
  logic             sync_last;

  // Mixing with exp(-j*pi/2*k), one quarter turn per sample.
  function automatic rx_types_pkg::iq_t rotate(
    input rx_types_pkg::iq_t s,
    input logic [PW-1:0]     ph
  );
    rx_types_pkg::iq_t r;
    case (ph)
      2'd0: begin
        r.i = s.i;
        r.q = s.q;
      end
      2'd1: begin
        r.i = s.q;
        r.q = -s.i;
      end
      2'd2: begin
        r.i = -s.i;
        r.q = -s.q;
      end
      default: begin
        r.i = -s.q;
        r.q = s.i;
      end
    endcase
    rotate = r;
  endfunction

  assign symb_last = (symb_n == SW'(NSYMB - 1));
  assign sync_last = symb_last && (loc_n == LOC_W'(NLOC_PER_SYNC - 1));

  always_ff @(posedge clk) begin
    if (i_reset | i_srst) begin
      phase  <= '0;
      symb_n <= '0;
      loc_n  <= '0;
    end else begin
      phase <= phase + 1'b1;
      if (symb_last) begin
        symb_n <= '0;
        loc_n  <= sync_last ? '0 : loc_n + 1'b1;
      end else begin
        symb_n <= symb_n + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_sync_ready <= 1'b0;
    end else begin
      o_sync_ready <= ~i_srst & sync_last;  // With the last sample of the interval.
    end
  end

  always_ff @(posedge clk) begin
    o_bb <= rotate(i_sample, phase);
  end

  assign o_debug = '{phase: phase, symb_n: symb_n, sync_count: 16'd0};

endmodule

/* preamble_detect/preamble_detect.sv */
module preamble_detect #(
  parameter int DEC_RATE = 64,  // Samples per energy block.
  parameter int NRX_TRIG = 16   // Blocks above threshold before a trigger.
)(
  input  logic                                clk,
  input  logic                                i_reset,
  input  logic                                i_clear,
  input  rx_types_pkg::iq_t                   i_sample,
  input  logic [2*rx_cfg_pkg::DATA_WIDTH-1:0] i_noise_thres,
  output logic                                o_peak_valid,
  output logic                                o_peak_stb,
  output logic                                o_peak_thres
);

  localparam int W     = rx_cfg_pkg::DATA_WIDTH;
  localparam int AW    = 2 * W;
  localparam int CNT_W = (DEC_RATE > 1) ? $clog2(DEC_RATE) : 1;
  localparam int RUN_W = $clog2(NRX_TRIG + 1);

  logic [CNT_W-1:0] samp_cnt;
  logic [RUN_W-1:0] run_n;      // Consecutive blocks above threshold.
  logic [AW-1:0]    acc;
  logic [AW-1:0]    block_sum;
  logic [W+1:0]     energy;
  logic             block_end;
  logic             above;

  // Magnitude in W+1 bits so that the most negative value is exact.
  function automatic logic [W:0] abs_val(input logic signed [W-1:0] x);
    logic [W:0] ext;
    ext = {x[W-1], x};
    abs_val = x[W-1] ? -ext : ext;
  endfunction

  //////////////////////////////
  // Block energy
  //////////////////////////////

  always_comb begin
    energy    = abs_val(i_sample.i) + abs_val(i_sample.q);
    block_sum = acc + AW'(energy);
    block_end = (samp_cnt == CNT_W'(DEC_RATE - 1));
    above     = (block_sum > i_noise_thres);  // Strictly greater.
  end

  //////////////////////////////
  // Threshold run and trigger
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset | i_clear) begin
      samp_cnt     <= '0;
      acc          <= '0;
      run_n        <= '0;
      o_peak_valid <= 1'b0;
      o_peak_stb   <= 1'b0;
      o_peak_thres <= 1'b0;
    end else begin
      o_peak_valid <= 1'b0;
      o_peak_stb   <= 1'b0;
      if (block_end) begin
        samp_cnt     <= '0;
        acc          <= '0;
        o_peak_valid <= 1'b1;
        o_peak_thres <= above;
        if (above) begin
          if (run_n != RUN_W'(NRX_TRIG)) begin
            run_n <= run_n + 1'b1;  // Saturates at NRX_TRIG.
          end
          o_peak_stb <= (run_n == RUN_W'(NRX_TRIG - 1));
        end else begin
          run_n <= '0;
        end
      end else begin
        samp_cnt <= samp_cnt + 1'b1;
        acc      <= block_sum;
      end
    end
  end

endmodule

/* source/iq_scaler.sv */
module iq_scaler (
  input  logic                                clk,
  input  logic                                i_reset,
  input  logic                                i_clear,
  input  logic [rx_cfg_pkg::DATA_WIDTH-1:0]   i_scale,
  input  rx_types_pkg::iq_t                   i_sample,
  output rx_types_pkg::iq_t                   o_sample
);

  localparam int W  = rx_cfg_pkg::DATA_WIDTH;
  localparam int PW = 2 * W + 1;  // Signed sample times unsigned scale.

  localparam longint MAX_VAL = 2**(W-1) - 1;
  localparam longint MIN_VAL = -(2**(W-1));

  function automatic logic signed [W-1:0] scale_sat(
    input logic signed [W-1:0] x,
    input logic        [W-1:0] s
  );
    logic signed [PW-1:0] prod;
    prod = x * $signed({1'b0, s});
    prod = prod >>> rx_cfg_pkg::SCALE_SHIFT;  // Rounds toward minus infinity.
    if (prod > MAX_VAL) begin
      scale_sat = {1'b0, {(W-1){1'b1}}};
    end else if (prod < MIN_VAL) begin
      scale_sat = {1'b1, {(W-1){1'b0}}};
    end else begin
      scale_sat = prod[W-1:0];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (i_reset | i_clear) begin
      o_sample <= '0;
    end else begin
      o_sample.i <= scale_sat(i_sample.i, i_scale);
      o_sample.q <= scale_sat(i_sample.q, i_scale);
    end
  end

endmodule

/* common/rx_types_pkg.sv */
package rx_types_pkg;

  // One complex sample, I in the upper half.
  typedef struct packed {
    logic signed [rx_cfg_pkg::DATA_WIDTH-1:0] i;
    logic signed [rx_cfg_pkg::DATA_WIDTH-1:0] q;
  } iq_t;

  typedef enum logic [1:0] {
    S_INIT     = rx_cfg_pkg::ST_INIT,
    S_LOC_SYNC = rx_cfg_pkg::ST_LOC_SYNC,
    S_LOC_RX   = rx_cfg_pkg::ST_LOC_RX
  } rx_state_t;

  // Field layout follows the GPIO bit positions.
  typedef struct packed {
    logic [rx_cfg_pkg::GPIO_WIDTH-rx_cfg_pkg::GPIO_THRES_BIT-2:0]    spare_hi;
    logic                                                          thres_trig;
    logic [rx_cfg_pkg::GPIO_THRES_BIT-rx_cfg_pkg::GPIO_SYNC_BIT-2:0] spare_lo;
    logic                                                          sync_out;
  } gpio_t;

  typedef struct packed {
    logic [rx_cfg_pkg::PHASE_WIDTH-1:0] phase;
    logic [rx_cfg_pkg::NSYMB_WIDTH-1:0] symb_n;
    logic [15:0]                        sync_count;
  } rx_debug_t;

endpackage

/* common/rx_cfg_pkg.sv */
package rx_cfg_pkg;

  //////////////////////////////
  // Data path widths
  //////////////////////////////

  localparam int DATA_WIDTH  = 16;  // I or Q component.
  localparam int PHASE_WIDTH = 2;   // Quarter turns.
  localparam int NSYMB_WIDTH = 16;

  // Scaled sample = (sample * scale) >>> SCALE_SHIFT.
  localparam int SCALE_SHIFT = 8;

  //////////////////////////////
  // Front panel GPIO
  //////////////////////////////

  localparam int GPIO_WIDTH     = 12;
  localparam int GPIO_SYNC_BIT  = 0;  // Sync pattern being sent.
  localparam int GPIO_THRES_BIT = 4;  // Last block above noise threshold.

  //////////////////////////////
  // Sync pattern and states
  //////////////////////////////

  localparam logic signed [DATA_WIDTH-1:0] SYNC_AMP = 16'sd16384;

  localparam logic [1:0] ST_INIT     = 2'b00;
  localparam logic [1:0] ST_LOC_SYNC = 2'b01;
  localparam logic [1:0] ST_LOC_RX   = 2'b11;

endpackage
